// File: design/vnu_ctrl_pkg.sv
package vnu_ctrl_pkg;

	//////////////////////////////////////////////////
	// schedule state encoding
	//////////////////////////////////////////////////
	localparam int STATE_W = 4;

	typedef enum logic [STATE_W-1:0] {
		INIT_LOAD   = 4'd0,  // kick off the initial lookup RAM load
		IB_RAM_PEND = 4'd1,  // wait for every load to complete
		CH_FETCH    = 4'd2,
		CH_BUBBLE   = 4'd3,
		MEM_FETCH   = 4'd4,
		VNU_PIPE    = 4'd5,
		VNU_OUT     = 4'd6,  // last VNU function cycle
		BS_WB       = 4'd7,  // barrel shift of v2c messages
		PAGE_ALIGN  = 4'd8,
		MEM_WB      = 4'd9,
		IDLE        = 4'd10
	} sched_state_t;

	//////////////////////////////////////////////////
	// default geometry and timing
	//////////////////////////////////////////////////
	localparam int DEF_LAYER_NUM              = 3;  // layers per iteration
	localparam int DEF_MAX_ITER               = 8;  // width of the iteration mask
	localparam int DEF_VN_GROUP_NUM           = 2;  // VNU lookup function groups
	localparam int DEF_VNU_FUNC_CYCLE         = 3;  // cycles per VNU function group
	localparam int DEF_CH_BUBBLE_LEVEL        = 2;
	localparam int DEF_MEM_RD_LEVEL           = 2;  // message memory read latency
	localparam int DEF_PERMUTATION_LEVEL      = 2;  // barrel shifter depth
	localparam int DEF_LOAD_HANDSHAKE_LATENCY = 3;  // load start to first write request

	localparam int TIMER_W = 4;  // stage timer, longest stage must fit

	//////////////////////////////////////////////////
	// strobes and load status
	//////////////////////////////////////////////////
	typedef struct packed {
		logic v2c_src;        // take v2c from channel values, very first layer only
		logic c2v_mem_fetch;
		logic v2c_bs_en;
		logic v2c_pa_en;
		logic v2c_mem_we;
		logic dnu_rd;
		logic layer_finish;
	} sched_strobe_t;

	localparam sched_strobe_t STROBE_NONE = '0;

	typedef struct packed {
		logic busy;    // load in flight, request or acknowledge outstanding
		logic finish;  // one cycle at the end of a load
	} load_status_t;

endpackage

// File: design/sched_stage_timer.sv
`timescale 1ns/10ps

module sched_stage_timer #(
	parameter int CH_BUBBLE_LEVEL   = vnu_ctrl_pkg::DEF_CH_BUBBLE_LEVEL,
	parameter int MEM_RD_LEVEL      = vnu_ctrl_pkg::DEF_MEM_RD_LEVEL,
	parameter int VNU_PIPE_LEN      = 5,
	parameter int PERMUTATION_LEVEL = vnu_ctrl_pkg::DEF_PERMUTATION_LEVEL
) (
	input  vnu_ctrl_pkg::sched_state_t       state_i,
	input  logic                             read_clk,
	input  logic                             rstn,
	output logic [vnu_ctrl_pkg::TIMER_W-1:0] stage_cnt_o,
	output logic                             stage_last_o
);

	localparam int TW = vnu_ctrl_pkg::TIMER_W;
	// longest fixed stage, bounds the count
	localparam int LEN_A   = (CH_BUBBLE_LEVEL > MEM_RD_LEVEL) ? CH_BUBBLE_LEVEL : MEM_RD_LEVEL;
	localparam int LEN_B   = (VNU_PIPE_LEN > PERMUTATION_LEVEL) ? VNU_PIPE_LEN : PERMUTATION_LEVEL;
	localparam int MAX_LEN = (LEN_A > LEN_B) ? LEN_A : LEN_B;

	vnu_ctrl_pkg::sched_state_t state_q;  // state seen last cycle
	logic [TW-1:0] run_q;                // count carried into the next cycle
	logic [TW-1:0] stage_len;

	// length of the current state in cycles
	always_comb begin
		case (state_i)
			vnu_ctrl_pkg::CH_BUBBLE: stage_len = TW'(CH_BUBBLE_LEVEL);
			vnu_ctrl_pkg::MEM_FETCH: stage_len = TW'(MEM_RD_LEVEL);
			vnu_ctrl_pkg::VNU_PIPE:  stage_len = TW'(VNU_PIPE_LEN);
			vnu_ctrl_pkg::BS_WB:     stage_len = TW'(PERMUTATION_LEVEL);
			default:                 stage_len = TW'(1);  // single cycle, or open ended pend
		endcase
	end

	assign stage_cnt_o  = (state_i != state_q) ? '0 : run_q;  // zero on entry
	assign stage_last_o = (stage_cnt_o == stage_len - 1'b1);

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= vnu_ctrl_pkg::INIT_LOAD;
			run_q   <= '0;
		end else begin
			state_q <= state_i;
			if (stage_last_o)
				run_q <= stage_cnt_o;  // hold, the FSM moves on or waits in pend
			else
				run_q <= stage_cnt_o + 1'b1;
		end
	end

	// count stays inside the longest stage, also across forced restarts
	a_cnt_bound: assert property (@(posedge read_clk) disable iff (!rstn)
		stage_cnt_o < TW'(MAX_LEN));

endmodule

// File: design/layer_sched_fsm.sv
`timescale 1ns/10ps

module layer_sched_fsm #(
	parameter int VN_GROUP_NUM   = vnu_ctrl_pkg::DEF_VN_GROUP_NUM,
	parameter int VNU_FUNC_CYCLE = vnu_ctrl_pkg::DEF_VNU_FUNC_CYCLE,
	parameter int VNU_PIPE_LEN   = 5
) (
	input  logic                              read_clk,
	input  logic                              rstn,
	input  logic                              fsm_en_i,
	input  logic                              termination_i,
	input  logic [vnu_ctrl_pkg::TIMER_W-1:0]  stage_cnt_i,
	input  logic                              stage_last_i,
	input  logic                              loads_busy_i,
	input  logic                              last_layer_i,
	input  logic                              first_layer_i,
	input  logic                              first_iter_i,
	output vnu_ctrl_pkg::sched_state_t        state_o,
	output vnu_ctrl_pkg::sched_strobe_t       strobe_o,
	output logic [VN_GROUP_NUM-1:0]           vnu_rd_o,
	output logic                              init_start_o,
	output logic                              vnu_pipe_start_o,
	output logic                              dnu_pipe_start_o,
	output logic                              update_pend_o
);

	localparam int TW = vnu_ctrl_pkg::TIMER_W;

	logic          pipe_act;  // VNU function window, VNU_OUT closes it
	logic [TW-1:0] pipe_idx;

	//////////////////////////////////////////////////
	// state register
	//////////////////////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state_o <= vnu_ctrl_pkg::INIT_LOAD;
		end else if (!fsm_en_i || termination_i) begin
			state_o <= vnu_ctrl_pkg::INIT_LOAD;  // abort the frame, reload
		end else begin
			case (state_o)
				vnu_ctrl_pkg::INIT_LOAD:   state_o <= vnu_ctrl_pkg::IB_RAM_PEND;
				vnu_ctrl_pkg::IB_RAM_PEND: begin
					if (!loads_busy_i)
						state_o <= vnu_ctrl_pkg::CH_FETCH;
				end
				vnu_ctrl_pkg::CH_FETCH:    state_o <= vnu_ctrl_pkg::CH_BUBBLE;
				vnu_ctrl_pkg::CH_BUBBLE: begin
					if (stage_last_i)
						state_o <= vnu_ctrl_pkg::MEM_FETCH;
				end
				vnu_ctrl_pkg::MEM_FETCH: begin
					if (stage_last_i)
						state_o <= vnu_ctrl_pkg::VNU_PIPE;
				end
				vnu_ctrl_pkg::VNU_PIPE: begin
					if (stage_last_i)
						state_o <= vnu_ctrl_pkg::VNU_OUT;
				end
				vnu_ctrl_pkg::VNU_OUT:     state_o <= vnu_ctrl_pkg::BS_WB;
				vnu_ctrl_pkg::BS_WB: begin
					if (stage_last_i)
						state_o <= vnu_ctrl_pkg::PAGE_ALIGN;
				end
				vnu_ctrl_pkg::PAGE_ALIGN:  state_o <= vnu_ctrl_pkg::MEM_WB;
				vnu_ctrl_pkg::MEM_WB:      state_o <= vnu_ctrl_pkg::IDLE;
				vnu_ctrl_pkg::IDLE: begin
					// pipe loads of the last layer hold the next layer back
					if (loads_busy_i)
						state_o <= vnu_ctrl_pkg::IB_RAM_PEND;
					else
						state_o <= vnu_ctrl_pkg::CH_FETCH;
				end
				default:                   state_o <= vnu_ctrl_pkg::INIT_LOAD;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// strobe decode
	//////////////////////////////////////////////////
	always_comb begin
		strobe_o = vnu_ctrl_pkg::STROBE_NONE;
		strobe_o.c2v_mem_fetch = (state_o == vnu_ctrl_pkg::MEM_FETCH) && (stage_cnt_i == '0);
		strobe_o.v2c_src       = (state_o == vnu_ctrl_pkg::MEM_FETCH) && stage_last_i &&
		                         first_layer_i && first_iter_i;
		strobe_o.v2c_bs_en     = (state_o == vnu_ctrl_pkg::BS_WB) && (stage_cnt_i == '0);
		strobe_o.v2c_pa_en     = (state_o == vnu_ctrl_pkg::PAGE_ALIGN);
		strobe_o.v2c_mem_we    = (state_o == vnu_ctrl_pkg::MEM_WB);
		strobe_o.dnu_rd        = (state_o == vnu_ctrl_pkg::BS_WB) ||
		                         (state_o == vnu_ctrl_pkg::PAGE_ALIGN);
		strobe_o.layer_finish  = (state_o == vnu_ctrl_pkg::MEM_WB);
	end

	// VNU_OUT counts as the final pipe cycle so every group gets full time
	assign pipe_act = (state_o == vnu_ctrl_pkg::VNU_PIPE) || (state_o == vnu_ctrl_pkg::VNU_OUT);
	assign pipe_idx = (state_o == vnu_ctrl_pkg::VNU_OUT) ? TW'(VNU_PIPE_LEN) : stage_cnt_i;

	for (genvar g = 0; g < VN_GROUP_NUM; g++) begin : g_vnu_rd
		assign vnu_rd_o[g] = pipe_act &&
		                     (pipe_idx >= TW'(g * VNU_FUNC_CYCLE)) &&
		                     (pipe_idx <  TW'((g + 1) * VNU_FUNC_CYCLE));
	end

	// load kicks, init waits for a live enable
	assign init_start_o     = (state_o == vnu_ctrl_pkg::INIT_LOAD) && fsm_en_i && !termination_i;
	assign vnu_pipe_start_o = (state_o == vnu_ctrl_pkg::VNU_OUT) && last_layer_i;
	assign dnu_pipe_start_o = (state_o == vnu_ctrl_pkg::MEM_WB) && last_layer_i;
	assign update_pend_o    = loads_busy_i;

	// write-back strobes never overlap
	a_wb_excl: assert property (@(posedge read_clk) disable iff (!rstn)
		$onehot0({strobe_o.v2c_bs_en, strobe_o.v2c_pa_en, strobe_o.v2c_mem_we}));

endmodule

// File: design/ib_ram_load_ctrl.sv
`timescale 1ns/10ps

module ib_ram_load_ctrl #(
	parameter int LOAD_HANDSHAKE_LATENCY = vnu_ctrl_pkg::DEF_LOAD_HANDSHAKE_LATENCY
) (
	input  logic                       read_clk,
	input  logic                       rstn,
	input  logic                       init_start_i,
	input  logic                       pipe_start_i,
	input  logic                       iter_update_i,  // updater acknowledge
	output logic                       wr_o,           // write request to updater
	output vnu_ctrl_pkg::load_status_t status_o
);

	localparam int CNT_W = $clog2(LOAD_HANDSHAKE_LATENCY + 1);

	logic [CNT_W-1:0] lat_cnt_q;  // cycles since the load started
	logic             busy_q;
	logic             wr_q;
	logic             finish_q;
	logic             pend_q;     // start seen while busy
	logic             start_any;
	logic             ack;

	// init and pipe loads share one sequencer
	assign start_any = init_start_i | pipe_start_i;
	assign ack       = wr_q & iter_update_i;  // ack without request is dropped

	//////////////////////////////////////////////////
	// request / acknowledge sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			lat_cnt_q <= '0;
			busy_q    <= 1'b0;
			wr_q      <= 1'b0;
			finish_q  <= 1'b0;
			pend_q    <= 1'b0;
		end else begin
			finish_q <= 1'b0;  // pulse only
			if (!busy_q) begin
				if (start_any) begin
					busy_q    <= 1'b1;
					lat_cnt_q <= CNT_W'(1);
				end
			end else if (ack) begin
				wr_q     <= 1'b0;
				finish_q <= 1'b1;
				if (pend_q || start_any) begin
					// next load follows straight away so busy stays up
					lat_cnt_q <= CNT_W'(1);
					pend_q    <= 1'b0;
				end else begin
					busy_q <= 1'b0;
				end
			end else begin
				if (start_any)
					pend_q <= 1'b1;
				if (!wr_q) begin
					if (lat_cnt_q >= CNT_W'(LOAD_HANDSHAKE_LATENCY - 1))
						wr_q <= 1'b1;  // request goes out and is held until acked
					else
						lat_cnt_q <= lat_cnt_q + 1'b1;
				end
			end
		end
	end

	assign wr_o     = wr_q;
	assign status_o = '{busy: busy_q, finish: finish_q};

	// the updater never sees a request outside a load
	a_wr_busy: assert property (@(posedge read_clk) disable iff (!rstn)
		wr_q |-> busy_q);

endmodule

// File: design/layer_iter_counter.sv
`timescale 1ns/10ps

module layer_iter_counter #(
	parameter int LAYER_NUM = vnu_ctrl_pkg::DEF_LAYER_NUM,
	parameter int MAX_ITER  = vnu_ctrl_pkg::DEF_MAX_ITER
) (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic                 layer_finish_i,
	output logic [LAYER_NUM-1:0] layer_cnt_o,   // one-hot with bit 0 for layer 0
	output logic                 last_layer_o,
	output logic                 first_layer_o,
	output logic                 first_iter_o
);

	logic [MAX_ITER-1:0] iter_q;  // shift mask with bit 0 set in the first iteration

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			layer_cnt_o <= LAYER_NUM'(1);
			iter_q      <= MAX_ITER'(1);
		end else if (layer_finish_i) begin
			layer_cnt_o <= {layer_cnt_o[LAYER_NUM-2:0], layer_cnt_o[LAYER_NUM-1]};  // rotate
			if (layer_cnt_o[LAYER_NUM-1])
				iter_q <= {iter_q[MAX_ITER-2:0], 1'b0};  // wrap to layer 0 starts next iteration
		end
	end

	assign last_layer_o  = layer_cnt_o[LAYER_NUM-1];
	assign first_layer_o = layer_cnt_o[0];
	assign first_iter_o  = iter_q[0];

endmodule

// File: design/vnu_control_unit.sv
`timescale 1ns/10ps

module vnu_control_unit #(
	parameter int LAYER_NUM              = vnu_ctrl_pkg::DEF_LAYER_NUM,
	parameter int MAX_ITER               = vnu_ctrl_pkg::DEF_MAX_ITER,
	parameter int VN_GROUP_NUM           = vnu_ctrl_pkg::DEF_VN_GROUP_NUM,
	parameter int VNU_FUNC_CYCLE         = vnu_ctrl_pkg::DEF_VNU_FUNC_CYCLE,
	parameter int CH_BUBBLE_LEVEL        = vnu_ctrl_pkg::DEF_CH_BUBBLE_LEVEL,
	parameter int MEM_RD_LEVEL           = vnu_ctrl_pkg::DEF_MEM_RD_LEVEL,
	parameter int PERMUTATION_LEVEL      = vnu_ctrl_pkg::DEF_PERMUTATION_LEVEL,
	parameter int LOAD_HANDSHAKE_LATENCY = vnu_ctrl_pkg::DEF_LOAD_HANDSHAKE_LATENCY
) (
	input  logic                        read_clk,
	input  logic                        rstn,
	input  logic                        fsm_en_i,
	input  logic                        termination_i,
	input  logic [VN_GROUP_NUM-1:0]     vn_iter_update_i,  // one ack per VNU group
	input  logic                        dn_iter_update_i,
	output vnu_ctrl_pkg::sched_state_t  state_o,
	output vnu_ctrl_pkg::sched_strobe_t strobe_o,
	output logic [VN_GROUP_NUM-1:0]     vnu_rd_o,
	output logic [VN_GROUP_NUM-1:0]     vnu_wr_o,
	output logic                        dnu_wr_o,
	output logic                        vnu_update_pend_o,
	output logic [LAYER_NUM-1:0]        layer_cnt_o,
	output logic                        last_layer_o
);

	// pipe stage is one short, VNU_OUT carries the final function cycle
	localparam int VNU_PIPE_LEN = VN_GROUP_NUM * VNU_FUNC_CYCLE - 1;

	logic [vnu_ctrl_pkg::TIMER_W-1:0] stage_cnt;
	logic                             stage_last;
	logic                             first_layer;
	logic                             first_iter;
	logic                             init_start;      // to every load controller
	logic                             vnu_pipe_start;
	logic                             dnu_pipe_start;
	logic                             loads_busy;
	logic [VN_GROUP_NUM-1:0]          vnu_busy;
	vnu_ctrl_pkg::load_status_t       vnu_status [VN_GROUP_NUM];
	vnu_ctrl_pkg::load_status_t       dnu_status;

	sched_stage_timer #(
		.CH_BUBBLE_LEVEL   (CH_BUBBLE_LEVEL),
		.MEM_RD_LEVEL      (MEM_RD_LEVEL),
		.VNU_PIPE_LEN      (VNU_PIPE_LEN),
		.PERMUTATION_LEVEL (PERMUTATION_LEVEL)
	) u_timer (
		.state_i      (state_o),
		.read_clk     (read_clk),
		.rstn         (rstn),
		.stage_cnt_o  (stage_cnt),
		.stage_last_o (stage_last)
	);

	layer_sched_fsm #(
		.VN_GROUP_NUM   (VN_GROUP_NUM),
		.VNU_FUNC_CYCLE (VNU_FUNC_CYCLE),
		.VNU_PIPE_LEN   (VNU_PIPE_LEN)
	) u_fsm (
		.read_clk         (read_clk),
		.rstn             (rstn),
		.fsm_en_i         (fsm_en_i),
		.termination_i    (termination_i),
		.stage_cnt_i      (stage_cnt),
		.stage_last_i     (stage_last),
		.loads_busy_i     (loads_busy),
		.last_layer_i     (last_layer_o),
		.first_layer_i    (first_layer),
		.first_iter_i     (first_iter),
		.state_o          (state_o),
		.strobe_o         (strobe_o),
		.vnu_rd_o         (vnu_rd_o),
		.init_start_o     (init_start),
		.vnu_pipe_start_o (vnu_pipe_start),
		.dnu_pipe_start_o (dnu_pipe_start),
		.update_pend_o    (vnu_update_pend_o)
	);

	layer_iter_counter #(
		.LAYER_NUM (LAYER_NUM),
		.MAX_ITER  (MAX_ITER)
	) u_layer_iter (
		.read_clk       (read_clk),
		.rstn           (rstn),
		.layer_finish_i (strobe_o.layer_finish),
		.layer_cnt_o    (layer_cnt_o),
		.last_layer_o   (last_layer_o),
		.first_layer_o  (first_layer),
		.first_iter_o   (first_iter)
	);

	//////////////////////////////////////////////////
	// lookup RAM load handshakes
	//////////////////////////////////////////////////
	for (genvar g = 0; g < VN_GROUP_NUM; g++) begin : g_vnu_load
		ib_ram_load_ctrl #(
			.LOAD_HANDSHAKE_LATENCY (LOAD_HANDSHAKE_LATENCY)
		) u_vnu_load (
			.read_clk      (read_clk),
			.rstn          (rstn),
			.init_start_i  (init_start),
			.pipe_start_i  (vnu_pipe_start),
			.iter_update_i (vn_iter_update_i[g]),
			.wr_o          (vnu_wr_o[g]),
			.status_o      (vnu_status[g])
		);
		assign vnu_busy[g] = vnu_status[g].busy;
	end

	ib_ram_load_ctrl #(
		.LOAD_HANDSHAKE_LATENCY (LOAD_HANDSHAKE_LATENCY)
	) u_dnu_load (
		.read_clk      (read_clk),
		.rstn          (rstn),
		.init_start_i  (init_start),
		.pipe_start_i  (dnu_pipe_start),  // DNU reloads after write-back of last layer
		.iter_update_i (dn_iter_update_i),
		.wr_o          (dnu_wr_o),
		.status_o      (dnu_status)
	);

	assign loads_busy = (|vnu_busy) | dnu_status.busy;  // any load holds the schedule

endmodule

// File: sim/tb_stim_table.svh
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

// columns: layers to run, cycles with fsm_en low before the run, layer offset of the
// termination pulse (0 for none), first expected layer, cycles per layer, vnu_rd and dnu_rd cycles
typedef struct packed {
	logic [7:0] n_layers;
	logic [7:0] en_low;       // fsm_en low this long, forces INIT_LOAD
	logic [7:0] term_off;     // offset from CH_FETCH, abort lands one cycle later
	logic [7:0] start_layer;  // layer_cnt does not restart with a new frame
	logic [7:0] layer_cycles;
	logic [7:0] vnu_cycles;   // per VNU group
	logic [7:0] dnu_cycles;
} stim_row_t;

localparam int ROW_NUM = 4;

localparam stim_row_t STIM_TABLE [ROW_NUM] = '{
	'{8'd4, 8'd2, 8'd0,  8'd0, 8'd16, 8'd3, 8'd3},  // plain start, wraps into iteration 1
	'{8'd3, 8'd3, 8'd7,  8'd1, 8'd16, 8'd3, 8'd3},  // abort inside VNU_PIPE
	'{8'd5, 8'd1, 8'd0,  8'd2, 8'd16, 8'd3, 8'd3},
	'{8'd1, 8'd4, 8'd12, 8'd1, 8'd16, 8'd3, 8'd3}   // abort last layer after its VNU reload
};

`endif

// File: sim/tb_vnu_control_unit.sv
`timescale 1ns/10ps

module tb_vnu_control_unit;

	localparam int LAYER_NUM         = vnu_ctrl_pkg::DEF_LAYER_NUM;
	localparam int VN_GROUP_NUM      = vnu_ctrl_pkg::DEF_VN_GROUP_NUM;
	localparam int VNU_FUNC_CYCLE    = vnu_ctrl_pkg::DEF_VNU_FUNC_CYCLE;
	localparam int CH_BUBBLE_LEVEL   = vnu_ctrl_pkg::DEF_CH_BUBBLE_LEVEL;
	localparam int MEM_RD_LEVEL      = vnu_ctrl_pkg::DEF_MEM_RD_LEVEL;
	localparam int PERMUTATION_LEVEL = vnu_ctrl_pkg::DEF_PERMUTATION_LEVEL;
	localparam int VNU_PIPE_CYCLES   = VN_GROUP_NUM * VNU_FUNC_CYCLE - 1;
	localparam int VNU_START         = 1 + CH_BUBBLE_LEVEL + MEM_RD_LEVEL;  // first VNU_PIPE offset
	localparam int START_TIMEOUT     = 200;
	localparam int RESP_TIMEOUT      = 1000;

	`include "tb_stim_table.svh"

	logic                        read_clk;
	logic                        rstn;
	logic                        fsm_en_i;
	logic                        termination_i;
	logic [VN_GROUP_NUM:0]       upd_q;   // updater acks with the DNU in the top bit
	vnu_ctrl_pkg::sched_state_t  state_o;
	vnu_ctrl_pkg::sched_strobe_t strobe_o;
	logic [VN_GROUP_NUM-1:0]     vnu_rd_o;
	logic [VN_GROUP_NUM-1:0]     vnu_wr_o;
	logic                        dnu_wr_o;
	logic                        vnu_update_pend_o;
	logic [LAYER_NUM-1:0]        layer_cnt_o;
	logic                        last_layer_o;
	logic [VN_GROUP_NUM:0]       wr_all;
	logic [VN_GROUP_NUM:0]       wr_seen;  // requests seen since last clear
	int                          errors;
	int                          checks;
	int                          exp_idx;   // model of the layer count
	int                          exp_iter;
	logic                        hung;

	assign wr_all = {dnu_wr_o, vnu_wr_o};

	vnu_control_unit #(
		.LAYER_NUM         (LAYER_NUM),
		.VN_GROUP_NUM      (VN_GROUP_NUM),
		.VNU_FUNC_CYCLE    (VNU_FUNC_CYCLE),
		.CH_BUBBLE_LEVEL   (CH_BUBBLE_LEVEL),
		.MEM_RD_LEVEL      (MEM_RD_LEVEL),
		.PERMUTATION_LEVEL (PERMUTATION_LEVEL)
	) i_dut (
		.read_clk          (read_clk),
		.rstn              (rstn),
		.fsm_en_i          (fsm_en_i),
		.termination_i     (termination_i),
		.vn_iter_update_i  (upd_q[VN_GROUP_NUM-1:0]),
		.dn_iter_update_i  (upd_q[VN_GROUP_NUM]),
		.state_o           (state_o),
		.strobe_o          (strobe_o),
		.vnu_rd_o          (vnu_rd_o),
		.vnu_wr_o          (vnu_wr_o),
		.dnu_wr_o          (dnu_wr_o),
		.vnu_update_pend_o (vnu_update_pend_o),
		.layer_cnt_o       (layer_cnt_o),
		.last_layer_o      (last_layer_o)
	);

	always #10 read_clk = ~read_clk;  // 20 ns period

	task automatic check_eq(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// outputs are settled at the falling edge
	task automatic sample();
		@(negedge read_clk);
		wr_seen = wr_seen | wr_all;
	endtask

	// stage order and lengths of one layer from CH_FETCH at offset 0
	function automatic vnu_ctrl_pkg::sched_state_t expected_state(input int off);
		int rest;
		rest = off;
		if (rest < 1)
			return vnu_ctrl_pkg::CH_FETCH;
		rest -= 1;
		if (rest < CH_BUBBLE_LEVEL)
			return vnu_ctrl_pkg::CH_BUBBLE;
		rest -= CH_BUBBLE_LEVEL;
		if (rest < MEM_RD_LEVEL)
			return vnu_ctrl_pkg::MEM_FETCH;
		rest -= MEM_RD_LEVEL;
		if (rest < VNU_PIPE_CYCLES)
			return vnu_ctrl_pkg::VNU_PIPE;
		rest -= VNU_PIPE_CYCLES;
		if (rest < 1)
			return vnu_ctrl_pkg::VNU_OUT;
		rest -= 1;
		if (rest < PERMUTATION_LEVEL)
			return vnu_ctrl_pkg::BS_WB;
		rest -= PERMUTATION_LEVEL;
		if (rest < 1)
			return vnu_ctrl_pkg::PAGE_ALIGN;
		if (rest < 2)
			return vnu_ctrl_pkg::MEM_WB;
		return vnu_ctrl_pkg::IDLE;
	endfunction

	//////////////////////////////////////////////////
	// lookup RAM updater model
	//////////////////////////////////////////////////
	task automatic respond(input int ch);
		int cnt;
		int delay;
		forever begin
			cnt = 0;
			while (!wr_all[ch] && cnt < RESP_TIMEOUT) begin
				@(negedge read_clk);
				cnt++;
			end
			if (!wr_all[ch]) begin
				$display("updater %0d saw no write request for %0d cycles", ch, RESP_TIMEOUT);
				errors++;
				return;
			end
			delay = $urandom % 6;  // back-pressure of 0 to 5 cycles
			repeat (delay) @(negedge read_clk);
			@(posedge read_clk);
			upd_q[ch] <= 1'b1;
			cnt = 0;
			while (wr_all[ch] && cnt < RESP_TIMEOUT) begin
				@(negedge read_clk);
				cnt++;
			end
			if (wr_all[ch]) begin
				$display("write request %0d stayed high after its acknowledge", ch);
				errors++;
				return;
			end
			@(posedge read_clk);
			upd_q[ch] <= 1'b0;  // hold ended with wr
		end
	endtask

	initial respond(0);
	initial respond(1);
	initial respond(2);

	//////////////////////////////////////////////////
	// scenario steps
	//////////////////////////////////////////////////
	// called right after the edge that forces INIT_LOAD is driven
	task automatic enter_init(input string cause);
		wr_seen = '0;
		sample();
		check_eq($sformatf("%s, INIT_LOAD", cause), state_o, vnu_ctrl_pkg::INIT_LOAD);
		sample();
		check_eq($sformatf("%s, IB_RAM_PEND", cause), state_o, vnu_ctrl_pkg::IB_RAM_PEND);
		check_eq($sformatf("%s, update pend", cause), vnu_update_pend_o, 1);
	endtask

	task automatic wait_layer_start(input logic expect_load);
		int cnt;
		int pend_cyc;
		cnt = 0;
		pend_cyc = 0;
		sample();
		while (state_o != vnu_ctrl_pkg::CH_FETCH && cnt < START_TIMEOUT) begin
			check_eq("state before CH_FETCH", state_o, vnu_ctrl_pkg::IB_RAM_PEND);
			if (vnu_update_pend_o)
				pend_cyc++;
			sample();
			cnt++;
		end
		if (state_o != vnu_ctrl_pkg::CH_FETCH) begin
			$display("schedule stuck, no CH_FETCH within %0d cycles", START_TIMEOUT);
			errors++;
			hung = 1'b1;
			return;
		end
		check_eq("wr outputs at CH_FETCH", wr_all, 0);
		check_eq("update pend at CH_FETCH", vnu_update_pend_o, 0);
		if (expect_load) begin
			check_eq("write requests before CH_FETCH", wr_seen, 2 ** (VN_GROUP_NUM + 1) - 1);
			check_eq("pend cycles seen", pend_cyc > 0, 1);
		end else begin
			check_eq("write requests without a load", wr_seen, 0);
			check_eq("pend cycles without a load", pend_cyc, 0);
		end
		wr_seen = '0;
	endtask

	// walks one layer from CH_FETCH through IDLE
	task automatic check_layer(input stim_row_t row, output logic load_next);
		int strobe_cnt [7];
		int strobe_exp [7];
		int rd_cnt [VN_GROUP_NUM];
		int rd_first [VN_GROUP_NUM];
		for (int b = 0; b < 7; b++) begin
			strobe_cnt[b] = 0;
			strobe_exp[b] = 1;  // single pulses
		end
		strobe_exp[6] = (exp_idx == 0 && exp_iter == 0) ? 1 : 0;  // v2c_src
		strobe_exp[1] = row.dnu_cycles;                            // dnu_rd
		for (int g = 0; g < VN_GROUP_NUM; g++) begin
			rd_cnt[g] = 0;
			rd_first[g] = -1;
		end
		check_eq("layer_cnt", layer_cnt_o, 1 << exp_idx);
		check_eq("last_layer", last_layer_o, exp_idx == LAYER_NUM - 1);
		load_next = (exp_idx == LAYER_NUM - 1);  // last layer reloads the RAMs
		for (int off = 0; off < int'(row.layer_cycles); off++) begin
			if (off > 0)
				sample();
			check_eq($sformatf("state at offset %0d", off), state_o, expected_state(off));
			for (int b = 0; b < 7; b++)
				strobe_cnt[b] += int'(strobe_o[b]);
			for (int g = 0; g < VN_GROUP_NUM; g++) begin
				if (vnu_rd_o[g]) begin
					rd_cnt[g]++;
					if (rd_first[g] < 0)
						rd_first[g] = off;
				end
			end
		end
		for (int b = 0; b < 7; b++)
			check_eq($sformatf("strobe bit %0d count", b), strobe_cnt[b], strobe_exp[b]);
		for (int g = 0; g < VN_GROUP_NUM; g++) begin
			check_eq($sformatf("vnu_rd[%0d] cycles", g), rd_cnt[g], row.vnu_cycles);
			check_eq($sformatf("vnu_rd[%0d] start", g), rd_first[g], VNU_START + g * VNU_FUNC_CYCLE);
		end
		if (exp_idx == LAYER_NUM - 1) begin
			exp_idx = 0;
			exp_iter++;
		end else begin
			exp_idx++;
		end
	endtask

	task automatic run_row(input stim_row_t row);
		logic load_next;
		exp_idx = int'(row.start_layer);
		@(posedge read_clk);
		fsm_en_i <= 1'b0;
		sample();
		repeat (row.en_low) begin
			sample();
			check_eq("state with fsm_en low", state_o, vnu_ctrl_pkg::INIT_LOAD);
		end
		@(posedge read_clk);
		fsm_en_i <= 1'b1;
		enter_init("fsm_en rise");
		load_next = 1'b1;  // init load
		for (int l = 0; l < int'(row.n_layers); l++) begin
			wait_layer_start(load_next);
			if (hung)
				return;
			check_layer(row, load_next);
		end
		if (row.term_off != 0) begin
			wait_layer_start(load_next);
			if (hung)
				return;
			repeat (row.term_off) sample();
			@(posedge read_clk);
			termination_i <= 1'b1;
			sample();
			@(posedge read_clk);
			termination_i <= 1'b0;
			enter_init("termination");
			wait_layer_start(1'b1);
			if (hung)
				return;
			check_layer(row, load_next);  // aborted layer runs again
		end
	endtask

	//////////////////////////////////////////////////
	// main flow
	//////////////////////////////////////////////////
	initial begin
		read_clk = 1'b0;
		rstn = 1'b0;
		fsm_en_i = 1'b0;
		termination_i = 1'b0;
		upd_q = '0;
		wr_seen = '0;
		errors = 0;
		checks = 0;
		exp_idx = 0;
		exp_iter = 0;
		hung = 1'b0;
		void'($urandom(96));
		repeat (2) @(posedge read_clk);
		rstn <= 1'b1;
		for (int r = 0; r < ROW_NUM; r++) begin
			if (!hung)
				run_row(STIM_TABLE[r]);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+sim
design/vnu_ctrl_pkg.sv
design/sched_stage_timer.sv
design/layer_sched_fsm.sv
design/ib_ram_load_ctrl.sv
design/layer_iter_counter.sv
design/vnu_control_unit.sv
sim/tb_vnu_control_unit.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_vnu_control_unit
FLIST    := flist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
